//--- rtl/fetch_pkg.sv
/*
	Fetch front end shared types
	Address and instruction types, queue and predictor sizes, stage structs
*/
package fetch_pkg;

	typedef logic [31:0] addr_t; // Byte address
	typedef logic [31:0] inst_t; // Fixed 32-bit instruction word

	localparam int ADDR_QUEUE_DEPTH = 4; // Outstanding fetch requests
	localparam int QUEUE_PTR_W = $clog2(ADDR_QUEUE_DEPTH);
	localparam int QUEUE_CNT_W = $clog2(ADDR_QUEUE_DEPTH + 1);

	// Index is address bits 4:2, tag is bits 31:5
	localparam int BTB_ENTRIES = 8;
	localparam int BTB_INDEX_W = $clog2(BTB_ENTRIES);
	typedef logic [BTB_INDEX_W-1:0] btb_index_t;
	typedef logic [31:BTB_INDEX_W+2] btb_tag_t;

	localparam logic [5:0] OP_BRANCH = 6'h04; // Top opcode bits of a branch
	localparam addr_t RESET_PC = 32'h0000_0000;

	typedef struct packed {
		logic kernel; // Supervisor mode
		logic paging; // Paging enabled
	} mode_t;

	typedef struct packed {
		addr_t addr;
		mode_t mode;
	} queue_entry_t;

	typedef struct packed {
		inst_t inst;
		addr_t pc;
		mode_t mode;
		logic pagefault;
		logic predicted;
		addr_t pred_target;
	} fetch_out_t;

	typedef struct packed {
		addr_t inst_addr;
		addr_t target;
		logic taken;
	} btb_update_t;

	typedef enum logic [1:0] {BOOT, RUN, HALT} fetch_state_t;

endpackage

//--- rtl/fetch_ctrl.sv
/*
	Fetch controller
	Program counter sequencer, request issue, redirect, flush and halt
*/
`timescale 1ns/1ps

module fetch_ctrl import fetch_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	// Exception side
	input logic exc_event,
	input logic exc_addr_set,
	input addr_t exc_addr,
	// Processor status
	input logic psr_kernel,
	input logic psr_paging,
	// Issue conditions
	input logic queue_full,
	input logic mem_busy,
	input logic decode_stall,
	// Prediction answer for the returning instruction
	input logic pred_hit,
	input addr_t pred_target,
	output logic mem_req,
	output addr_t mem_addr,
	output queue_entry_t push_entry,
	output logic flush,
	output logic kill
);

	fetch_state_t state;
	addr_t pc;
	logic exc_any;

	assign exc_any = exc_event || exc_addr_set;

	// Prediction only redirects when no exception owns this cycle
	assign flush = pred_hit && !exc_any;
	assign kill = exc_event || flush; // Empties the queue and the out stage

	always_comb begin
		mem_req = (state == RUN) && !queue_full && !mem_busy && !decode_stall
			&& !flush && !exc_any;
	end

	assign mem_addr = pc;

	// Mode bits captured at request time
	always_comb begin
		push_entry.addr = pc;
		push_entry.mode.kernel = psr_kernel;
		push_entry.mode.paging = psr_paging;
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= BOOT;
			pc <= RESET_PC;
		end else if (exc_addr_set) begin
			// New exception vector, bit 0 dropped
			pc <= {exc_addr[31:1], 1'b0};
			state <= RUN;
		end else if (exc_event) begin
			state <= HALT; // Wait for an address
		end else if (flush) begin
			pc <= pred_target;
			state <= RUN;
		end else begin
			case (state)
				BOOT: begin
					pc <= RESET_PC;
					state <= RUN;
				end
				RUN: begin
					if (mem_req) begin
						pc <= pc + 32'd4;
					end
				end
				HALT: begin
					state <= HALT;
				end
				default: begin
					state <= HALT;
				end
			endcase
		end
	end

endmodule

//--- rtl/fetch_addr_queue.sv
/*
	Fetch address queue
	In-order buffer of outstanding request addresses with their mode bits
*/
`timescale 1ns/1ps

module fetch_addr_queue import fetch_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic clear,
	input logic push,
	input queue_entry_t push_entry,
	input logic pop,
	output logic full,
	output queue_entry_t head
);

	queue_entry_t mem [ADDR_QUEUE_DEPTH];
	logic [QUEUE_PTR_W-1:0] wr_ptr;
	logic [QUEUE_PTR_W-1:0] rd_ptr;
	logic [QUEUE_CNT_W-1:0] count;

	assign full = (count == QUEUE_CNT_W'(ADDR_QUEUE_DEPTH));
	assign head = mem[rd_ptr]; // Oldest request

	// Entry storage
	always_ff @(posedge iCLOCK) begin
		if (push && !clear) begin
			mem[wr_ptr] <= push_entry;
		end
	end

	// Pointers wrap naturally, depth is a power of two
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

endmodule

//--- rtl/branch_target_buffer.sv
/*
	Branch target buffer
	Direct-mapped taken-branch predictor with lookup and training ports
*/
`timescale 1ns/1ps

module branch_target_buffer import fetch_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	// Lookup from the returning instruction
	input logic lookup,
	input addr_t lookup_addr,
	// Training from execute
	input logic train,
	input btb_update_t update,
	output logic hit,
	output addr_t target
);

	logic [BTB_ENTRIES-1:0] valid;
	btb_tag_t tag_mem [BTB_ENTRIES];
	addr_t target_mem [BTB_ENTRIES];

	btb_index_t lookup_idx;
	btb_tag_t lookup_tag;
	btb_index_t train_idx;
	btb_tag_t train_tag;

	// Address fields
	always_comb begin
		lookup_idx = lookup_addr[BTB_INDEX_W+1:2];
		lookup_tag = lookup_addr[31:BTB_INDEX_W+2];
		train_idx = update.inst_addr[BTB_INDEX_W+1:2];
		train_tag = update.inst_addr[31:BTB_INDEX_W+2];
	end

	always_comb begin
		hit = lookup && valid[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
		target = target_mem[lookup_idx];
	end

	// Taken fills the entry, not-taken drops it
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid <= '0;
		end else if (train) begin
			valid[train_idx] <= update.taken;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (train && update.taken) begin
			tag_mem[train_idx] <= train_tag;
			target_mem[train_idx] <= update.target;
		end
	end

endmodule

//--- rtl/fetch_out_stage.sv
/*
	Fetch output stage
	Registered result to decode, held on stall and cleared on kill
*/
`timescale 1ns/1ps

module fetch_out_stage import fetch_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic clear,
	input logic stall,
	input logic in_valid,
	input fetch_out_t in,
	output logic out_valid,
	output fetch_out_t out
);

	fetch_out_t stage;
	logic stage_valid;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			stage_valid <= 1'b0;
			stage <= '0;
		end else if (clear) begin
			// Older contents are dropped
			// an instruction accepted in the kill cycle still lands
			stage_valid <= in_valid;
			stage <= in_valid ? in : '0;
		end else if (!stall) begin
			stage_valid <= in_valid;
			stage <= in;
		end
	end

	assign out_valid = stage_valid;
	assign out = stage;

endmodule

//--- rtl/fetch_unit.sv
/*
	Instruction fetch front end
	Ties the controller, address queue, predictor and output stage together
*/
`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	// Processor status
	input logic psr_kernel,
	input logic psr_paging,
	// Exception
	input logic exc_event,
	input logic exc_addr_set,
	input addr_t exc_addr,
	// Instruction memory
	output logic mem_req,
	output addr_t mem_addr,
	input logic mem_busy,
	input logic mem_valid,
	input inst_t mem_inst,
	input logic mem_pagefault,
	output logic mem_hold,
	// Decode
	output logic out_valid,
	output fetch_out_t out,
	input logic decode_stall,
	// Predictor training
	input logic btb_train,
	input btb_update_t btb_update,
	output logic fetch_flush
);

	logic queue_full, kill, accept, lookup, pred_hit;
	addr_t pred_target;
	queue_entry_t push_entry, head;
	fetch_out_t resp;

	assign mem_hold = decode_stall; // Memory keeps its response while decode waits
	assign accept = mem_valid && !decode_stall;
	assign lookup = accept && (mem_inst[31:26] == OP_BRANCH);

	always_comb begin
		resp.inst = mem_inst;
		resp.pc = head.addr;
		resp.mode = head.mode;
		resp.pagefault = mem_pagefault;
		resp.predicted = fetch_flush;
		resp.pred_target = pred_target;
	end

	fetch_ctrl u_ctrl (.iCLOCK, .inRESET, .exc_event, .exc_addr_set, .exc_addr,
		.psr_kernel, .psr_paging, .queue_full, .mem_busy, .decode_stall, .pred_hit,
		.pred_target, .mem_req, .mem_addr, .push_entry, .flush(fetch_flush), .kill);

	fetch_addr_queue u_queue (.iCLOCK, .inRESET, .clear(kill), .push(mem_req),
		.push_entry, .pop(accept), .full(queue_full), .head);

	branch_target_buffer u_btb (.iCLOCK, .inRESET, .lookup, .lookup_addr(head.addr),
		.train(btb_train), .update(btb_update), .hit(pred_hit), .target(pred_target));

	// A response arriving with an exception is discarded
	fetch_out_stage u_out (.iCLOCK, .inRESET, .clear(kill), .stall(decode_stall),
		.in_valid(accept && !exc_event), .in(resp), .out_valid, .out);

endmodule

//--- bench/clock_gen.sv
/*
	Testbench clock and reset, 8 ns period, reset low for five cycles
*/
`timescale 1ns/1ps

module clock_gen (
	output logic clock,
	output logic reset_n
);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin
		reset_n = 1'b0;
		repeat (5) @(posedge clock);
		reset_n <= 1'b1; // Released on an edge
	end

endmodule

//--- bench/fetch_tb.sv
/*
	Fetch unit testbench
	Memory model, predictor reference model and in-order output checking
*/
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

	logic iCLOCK, inRESET;
	logic psr_kernel, psr_paging;
	logic exc_event, exc_addr_set;
	addr_t exc_addr;
	logic mem_req, mem_busy, mem_valid, mem_pagefault, mem_hold;
	addr_t mem_addr;
	inst_t mem_inst;
	logic out_valid, decode_stall, btb_train, fetch_flush;
	fetch_out_t out;
	btb_update_t btb_update;

	int consumed; // Outputs taken by decode
	int redirect_count; // Bumped by every exception address
	addr_t redirect_addr;
	logic slow_mem;
	logic ref_valid [BTB_ENTRIES];
	logic [26:0] ref_tag [BTB_ENTRIES];
	addr_t ref_target [BTB_ENTRIES];
	addr_t pend_addr [$]; // Requests memory still owes
	int pend_ready [$];

	clock_gen clocks (.clock(iCLOCK), .reset_n(inRESET));
	fetch_unit uut (.*);

	function automatic logic is_branch_addr(addr_t a);
		return (a == 32'h40) || (a == 32'h124);
	endfunction

	function automatic inst_t mem_word(addr_t a);
		addr_t mix;
		mix = a ^ (a >> 7) ^ 32'h0135_79BD; // Whole address in the pattern
		if (is_branch_addr(a)) begin
			return {OP_BRANCH, mix[25:0]};
		end
		return {6'h11, mix[25:0]};
	endfunction

	function automatic logic page_fault(addr_t a);
		return (a[5:2] == 4'hB) && a[8];
	endfunction

	function automatic logic ref_hit(addr_t a);
		inst_t w;
		w = mem_word(a);
		return (w[31:26] == OP_BRANCH) && ref_valid[a[4:2]] && (ref_tag[a[4:2]] == a[31:5]);
	endfunction

	// Expected pc of the next output
	function automatic addr_t next_pc(addr_t prev_pc, logic pred, addr_t pred_target,
		logic redirect, addr_t new_addr);
		if (redirect) begin
			return new_addr & ~32'h1;
		end
		if (pred) begin
			return pred_target;
		end
		return prev_pc + 32'd4;
	endfunction

	task automatic fail_now(string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_inst(string name, inst_t got, inst_t exp);
		if (got !== exp) begin
			fail_now($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_addr(string name, addr_t got, addr_t exp);
		if (got !== exp) begin
			fail_now($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			fail_now($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
		end
	endtask

	// In-order memory with random latency, busy cycles and hold
	initial begin
		int lat;
		int now;
		now = 0;
		mem_busy = 1'b0;
		mem_valid = 1'b0;
		mem_inst = '0;
		mem_pagefault = 1'b0;
		forever begin
			@(posedge iCLOCK);
			now++;
			if (!inRESET) begin
				pend_addr.delete();
				pend_ready.delete();
				mem_valid <= 1'b0;
			end else begin
				if (fetch_flush || exc_event) begin
					pend_addr.delete(); // Everything in flight is dropped
					pend_ready.delete();
				end else if (mem_valid && !mem_hold) begin
					void'(pend_addr.pop_front());
					void'(pend_ready.pop_front());
				end
				if (mem_req) begin
					if (mem_busy) begin
						fail_now("a request was issued while memory was busy");
					end
					lat = slow_mem ? 3 + int'($urandom % 6) : 1 + int'($urandom % 3);
					pend_addr.push_back(mem_addr);
					pend_ready.push_back(now + lat - 1);
				end
				if (pend_addr.size() > ADDR_QUEUE_DEPTH) begin
					fail_now("more requests are outstanding than the queue can hold");
				end
				mem_busy <= ($urandom % (slow_mem ? 3 : 6)) == 0;
				if (pend_addr.size() > 0 && pend_ready[0] <= now) begin
					mem_valid <= 1'b1;
					mem_inst <= mem_word(pend_addr[0]);
					mem_pagefault <= page_fault(pend_addr[0]);
				end else begin
					mem_valid <= 1'b0;
				end
			end
		end
	end

	// Checks every output that decode takes
	initial begin
		fetch_out_t held;
		logic held_valid;
		addr_t exp_pc, last_pc, last_target;
		logic exp_pred, last_pred;
		int seen;
		held_valid = 1'b0;
		consumed = 0;
		seen = 0;
		last_pc = RESET_PC;
		last_pred = 1'b0;
		last_target = '0;
		forever begin
			@(posedge iCLOCK);
			if (!inRESET) begin
				check_flag("mem_req", mem_req, 1'b0);
				check_flag("out_valid", out_valid, 1'b0);
				check_flag("fetch_flush", fetch_flush, 1'b0);
			end else begin
				if (held_valid) begin
					check_flag("out_valid", out_valid, 1'b1);
					check_addr("out.pc", out.pc, held.pc);
					check_inst("out.inst", out.inst, held.inst);
					check_flag("out.predicted", out.predicted, held.predicted);
				end
				check_flag("mem_hold", mem_hold, decode_stall); // Memory waits with decode
				if (decode_stall) begin
					check_flag("mem_req", mem_req, 1'b0); // No requests under stall
				end
				if (out_valid && !decode_stall) begin
					exp_pc = next_pc(last_pc, last_pred, last_target, seen != redirect_count,
						redirect_addr);
					seen = redirect_count;
					exp_pred = ref_hit(exp_pc);
					check_addr("out.pc", out.pc, exp_pc);
					check_inst("out.inst", out.inst, mem_word(exp_pc));
					check_flag("out.mode.kernel", out.mode.kernel, psr_kernel);
					check_flag("out.mode.paging", out.mode.paging, psr_paging);
					check_flag("out.pagefault", out.pagefault, page_fault(exp_pc));
					check_flag("out.predicted", out.predicted, exp_pred);
					if (exp_pred) begin
						check_addr("out.pred_target", out.pred_target, ref_target[exp_pc[4:2]]);
					end
					last_pc = exp_pc;
					last_pred = exp_pred;
					last_target = ref_target[exp_pc[4:2]];
					consumed++;
				end
			end
			held_valid = inRESET && out_valid && decode_stall;
			held = out;
		end
	end

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		while (inRESET !== 1'b1) begin
			@(posedge iCLOCK);
			waited++;
			if (waited > 20) begin
				fail_now("reset was never released");
			end
		end
	endtask

	task automatic run_outputs(int n, bit stalls);
		int target;
		int waited;
		target = consumed + n;
		waited = 0;
		while (consumed < target) begin
			@(posedge iCLOCK);
			decode_stall <= stalls && (($urandom % 5) == 0);
			waited++;
			if (waited > 40 * n + 100) begin
				fail_now("timed out waiting for fetch outputs");
			end
		end
		@(posedge iCLOCK);
		decode_stall <= 1'b0;
	endtask

	// Exception without an address keeps fetch quiet
	task automatic halt_fetch();
		@(posedge iCLOCK);
		exc_event <= 1'b1;
		@(posedge iCLOCK);
		exc_event <= 1'b0;
		repeat (6) begin
			@(posedge iCLOCK);
			check_flag("mem_req", mem_req, 1'b0);
			check_flag("out_valid", out_valid, 1'b0);
		end
	endtask

	task automatic redirect_to(addr_t a);
		@(posedge iCLOCK);
		exc_addr_set <= 1'b1;
		exc_addr <= a;
		redirect_addr = a;
		redirect_count++;
		@(posedge iCLOCK);
		exc_addr_set <= 1'b0;
	endtask

	task automatic train(addr_t a, addr_t t, logic taken);
		@(posedge iCLOCK);
		btb_train <= 1'b1;
		btb_update.inst_addr <= a;
		btb_update.target <= t;
		btb_update.taken <= taken;
		ref_valid[a[4:2]] = taken; // Not-taken drops the entry
		if (taken) begin
			ref_tag[a[4:2]] = a[31:5];
			ref_target[a[4:2]] = t;
		end
		@(posedge iCLOCK);
		btb_train <= 1'b0;
	endtask

	initial begin
		void'($urandom(59615));
		psr_kernel = 1'b1;
		psr_paging = 1'b0;
		exc_event = 1'b0;
		exc_addr_set = 1'b0;
		exc_addr = '0;
		decode_stall = 1'b0;
		btb_train = 1'b0;
		btb_update = '0;
		slow_mem = 1'b0;
		redirect_addr = RESET_PC; // First output comes from the reset pc
		redirect_count = 1;
		for (int i = 0; i < BTB_ENTRIES; i++) begin
			ref_valid[i] = 1'b0;
		end
		wait_reset_release();
		run_outputs(24, 1'b1);
		halt_fetch();
		psr_kernel <= 1'b0;
		psr_paging <= 1'b1;
		redirect_to(32'h0000_0201);
		run_outputs(10, 1'b1);
		halt_fetch();
		train(32'h40, 32'h100, 1'b1);
		redirect_to(32'h30);
		run_outputs(12, 1'b1); // Through the predicted branch into 0x100
		halt_fetch();
		train(32'h40, 32'h100, 1'b0);
		redirect_to(32'h38);
		run_outputs(8, 1'b0);
		halt_fetch();
		slow_mem = 1'b1;
		psr_kernel <= 1'b1;
		redirect_to(32'h110);
		run_outputs(24, 1'b1); // Page faults at 0x12c and 0x16c
		$display("All checks passed");
		$finish;
	end

endmodule

//--- build.f
rtl/fetch_pkg.sv
rtl/fetch_ctrl.sv
rtl/fetch_addr_queue.sv
rtl/branch_target_buffer.sv
rtl/fetch_out_stage.sv
rtl/fetch_unit.sv
bench/clock_gen.sv
bench/fetch_tb.sv

//--- Makefile
# Verilator build and run for the fetch unit testbench

VERILATOR ?= verilator
TOP ?= fetch_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary -j 0
PASS_MSG ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
